// ==== hw/gfx_fade_settings.svh ====
`ifndef GFX_FADE_SETTINGS_SVH
`define GFX_FADE_SETTINGS_SVH

// horizontal timing in pixels
`define H_VISIBLE 16
`define H_FRONT 2
`define H_SYNC 3
`define H_BACK 3
`define H_TOTAL 24

// vertical timing in lines
`define V_VISIBLE 12
`define V_FRONT 1
`define V_SYNC 2
`define V_BACK 1
`define V_TOTAL 16

// pixel and framebuffer geometry
`define PIXEL_BITS 12
`define COLOR_BITS 4
`define AGE_BITS 4
`define FB_WORDS 192
`define FB_ADDR_BITS 8

// fade ages
`define AGE_NEW 4
`define AGE_DIM 2

// writeback queue
`define WB_FIFO_DEPTH 8
`define WB_ALMOST_FULL 4

`endif

// ==== hw/gfx_fade_pkg.sv ====
`include "gfx_fade_settings.svh"

package gfx_fade_pkg;

  // red in the top channel, then green, then blue
  typedef logic [`PIXEL_BITS-1:0] pixel_t;
  typedef logic [`COLOR_BITS-1:0] channel_t;
  typedef logic [`AGE_BITS-1:0] age_t;

  // stored word, age above the color
  typedef logic [`AGE_BITS+`PIXEL_BITS-1:0] fb_word_t;
  typedef logic [`FB_ADDR_BITS-1:0] fb_addr_t;

  // scan coordinates cover the whole line and frame, not only the visible part
  typedef logic [$clog2(`H_TOTAL)-1:0] col_t;
  typedef logic [$clog2(`V_TOTAL)-1:0] row_t;

  typedef enum logic [1:0] {hs_visible, hs_front, hs_sync, hs_back} h_state_t;
  typedef enum logic [1:0] {vs_visible, vs_front, vs_sync, vs_back} v_state_t;

endpackage

// ==== hw/vga_scan_timing.sv ====
`timescale 1ns/1ns

`include "gfx_fade_settings.svh"

module vga_scan_timing
  import gfx_fade_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     advance,
  output logic     rd_en,
  output fb_addr_t rd_addr,
  output logic     hsync,
  output logic     vsync,
  output logic     visible
);

  col_t     h_cnt;
  row_t     v_cnt;
  h_state_t h_state;
  v_state_t v_state;

  // position counters, x-major, frozen while advance is low
  always_ff @(posedge clk) begin
    if (rst) begin
      h_cnt <= '0;
      v_cnt <= '0;
    end else if (advance) begin
      if (h_cnt == col_t'(`H_TOTAL - 1)) begin
        h_cnt <= '0;
        if (v_cnt == row_t'(`V_TOTAL - 1)) begin
          v_cnt <= '0;
        end else begin
          v_cnt <= v_cnt + row_t'(1);
        end
      end else begin
        h_cnt <= h_cnt + col_t'(1);
      end
    end
  end

  // region of the line
  always_comb begin
    if (h_cnt < col_t'(`H_VISIBLE)) begin
      h_state = hs_visible;
    end else if (h_cnt < col_t'(`H_VISIBLE + `H_FRONT)) begin
      h_state = hs_front;
    end else if (h_cnt < col_t'(`H_VISIBLE + `H_FRONT + `H_SYNC)) begin
      h_state = hs_sync;
    end else begin
      h_state = hs_back;
    end
  end

  // region of the frame
  always_comb begin
    if (v_cnt < row_t'(`V_VISIBLE)) begin
      v_state = vs_visible;
    end else if (v_cnt < row_t'(`V_VISIBLE + `V_FRONT)) begin
      v_state = vs_front;
    end else if (v_cnt < row_t'(`V_VISIBLE + `V_FRONT + `V_SYNC)) begin
      v_state = vs_sync;
    end else begin
      v_state = vs_back;
    end
  end

  // syncs are active low
  assign hsync   = (h_state != hs_sync);
  assign vsync   = (v_state != vs_sync);
  assign visible = (h_state == hs_visible) && (v_state == vs_visible);

  assign rd_en   = advance;
  assign rd_addr = visible ?
                   fb_addr_t'(v_cnt) * fb_addr_t'(`H_VISIBLE) + fb_addr_t'(h_cnt) : '0;

endmodule

// ==== hw/frame_buffer.sv ====
`timescale 1ns/1ns

`include "gfx_fade_settings.svh"

module frame_buffer
  import gfx_fade_pkg::*;
(
  input  logic     clk,
  input  logic     rd_en,
  input  fb_addr_t rd_addr,
  output fb_word_t rd_data,
  input  logic     wr_en,
  input  fb_addr_t wr_addr,
  input  fb_word_t wr_data
);

  fb_word_t mem [`FB_WORDS];

  // synchronous write
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // registered read, holds its value between reads
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

// ==== hw/fade_stage.sv ====
`timescale 1ns/1ns

`include "gfx_fade_settings.svh"

module fade_stage
  import gfx_fade_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     rd_valid,
  input  fb_word_t rd_data,
  input  fb_addr_t rd_addr,
  input  logic     hsync_in,
  input  logic     vsync_in,
  input  logic     visible_in,
  output logic     vga_valid,
  output logic     vga_hsync,
  output logic     vga_vsync,
  output channel_t vga_red,
  output channel_t vga_grn,
  output channel_t vga_blu,
  output logic     wb_push,
  output fb_addr_t wb_addr,
  output fb_word_t wb_word
);

  logic     visible_q;
  fb_addr_t addr_q;
  age_t     cur_age;
  pixel_t   cur_color;
  pixel_t   shown;
  age_t     next_age;
  pixel_t   next_color;

  // line the scan flags up with the memory read data
  always_ff @(posedge clk) begin
    if (rst) begin
      vga_valid <= 1'b0;
      vga_hsync <= 1'b1;
      vga_vsync <= 1'b1;
      visible_q <= 1'b0;
    end else begin
      vga_valid <= rd_valid;
      vga_hsync <= hsync_in;
      vga_vsync <= vsync_in;
      visible_q <= visible_in;
    end
  end

  always_ff @(posedge clk) begin
    addr_q <= rd_addr;
  end

  assign {cur_age, cur_color} = rd_data;

  // blank outside the visible area
  assign shown = visible_q ? cur_color : '0;
  assign {vga_red, vga_grn, vga_blu} = shown;

  // fade rule: one step older, dim at AGE_DIM, black at zero
  always_comb begin
    next_age   = cur_age - age_t'(1);
    next_color = cur_color;
    if (next_age == age_t'(`AGE_DIM)) begin
      next_color = {cur_color[11:8] >> 1, cur_color[7:4] >> 1, cur_color[3:0] >> 1};
    end
    if (next_age == '0) begin
      next_color = '0;
    end
  end

  // only lit pixels that still have an age come back for a writeback
  always_ff @(posedge clk) begin
    if (rst) begin
      wb_push <= 1'b0;
    end else begin
      wb_push <= vga_valid && visible_q && (|cur_color) && (|cur_age);
    end
  end

  always_ff @(posedge clk) begin
    wb_addr <= addr_q;
    wb_word <= {next_age, next_color};
  end

endmodule

// ==== hw/fade_writeback_fifo.sv ====
`timescale 1ns/1ns

`include "gfx_fade_settings.svh"

module fade_writeback_fifo
  import gfx_fade_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     push,
  input  fb_addr_t push_addr,
  input  fb_word_t push_word,
  input  logic     pop,
  output fb_addr_t pop_addr,
  output fb_word_t pop_word,
  output logic     empty,
  output logic     almost_full
);

  typedef logic [$clog2(`WB_FIFO_DEPTH)-1:0] ptr_t;
  typedef logic [$clog2(`WB_FIFO_DEPTH):0] count_t;

  fb_addr_t addr_mem [`WB_FIFO_DEPTH];
  fb_word_t word_mem [`WB_FIFO_DEPTH];
  ptr_t     wr_ptr;
  ptr_t     rd_ptr;
  count_t   count;
  logic     full;
  logic     do_push;
  logic     do_pop;

  assign full    = (count == count_t'(`WB_FIFO_DEPTH));
  assign empty   = (count == '0);
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  // at most WB_ALMOST_FULL free slots left
  assign almost_full = (count >= count_t'(`WB_FIFO_DEPTH - `WB_ALMOST_FULL));

  always_ff @(posedge clk) begin
    if (do_push) begin
      addr_mem[wr_ptr] <= push_addr;
      word_mem[wr_ptr] <= push_word;
    end
  end

  // pointers wrap on their own since the depth is a power of two
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= wr_ptr + ptr_t'(1);
      if (do_pop) rd_ptr <= rd_ptr + ptr_t'(1);
      count <= count + count_t'(do_push) - count_t'(do_pop);
    end
  end

  // head entry is visible without a pop
  assign pop_addr = addr_mem[rd_ptr];
  assign pop_word = word_mem[rd_ptr];

endmodule

// ==== hw/fb_write_arbiter.sv ====
`timescale 1ns/1ns

`include "gfx_fade_settings.svh"

module fb_write_arbiter
  import gfx_fade_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     wb_empty,
  input  fb_addr_t wb_addr,
  input  fb_word_t wb_word,
  output logic     wb_pop,
  input  col_t     gfx_x,
  input  row_t     gfx_y,
  input  pixel_t   gfx_color,
  input  logic     gfx_valid,
  output logic     gfx_ready,
  output logic     wr_en,
  output fb_addr_t wr_addr,
  output fb_word_t wr_data
);

  fb_addr_t gfx_addr;

  // fade writebacks always win
  assign wb_pop    = !wb_empty;
  assign gfx_ready = wb_empty;

  assign gfx_addr = fb_addr_t'(gfx_y) * fb_addr_t'(`H_VISIBLE) + fb_addr_t'(gfx_x);

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_en <= 1'b0;
    end else begin
      wr_en <= wb_pop || (gfx_valid && gfx_ready);
    end
  end

  // a fresh pixel starts at full age
  always_ff @(posedge clk) begin
    wr_addr <= wb_pop ? wb_addr : gfx_addr;
    wr_data <= wb_pop ? wb_word : {age_t'(`AGE_NEW), gfx_color};
  end

endmodule

// ==== hw/gfx_fade_display.sv ====
`timescale 1ns/1ns

module gfx_fade_display
  import gfx_fade_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  col_t     gfx_x,
  input  row_t     gfx_y,
  input  pixel_t   gfx_color,
  input  logic     gfx_valid,
  output logic     gfx_ready,
  input  logic     vga_enable,
  output logic     vga_valid,
  output logic     vga_hsync,
  output logic     vga_vsync,
  output channel_t vga_red,
  output channel_t vga_grn,
  output channel_t vga_blu
);

  logic     scan_adv;
  logic     rd_en;
  fb_addr_t rd_addr;
  fb_word_t rd_data;
  logic     scan_hsync;
  logic     scan_vsync;
  logic     scan_visible;

  logic     wb_push;
  fb_addr_t wb_push_addr;
  fb_word_t wb_push_word;
  logic     wb_pop;
  fb_addr_t wb_pop_addr;
  fb_word_t wb_pop_word;
  logic     wb_empty;
  logic     wb_almost_full;

  logic     wr_en;
  fb_addr_t wr_addr;
  fb_word_t wr_data;

  // the scan stalls rather than lose a writeback
  assign scan_adv = vga_enable && !wb_almost_full;

  vga_scan_timing scan_inst (
    .clk     (clk),
    .rst     (rst),
    .advance (scan_adv),
    .rd_en   (rd_en),
    .rd_addr (rd_addr),
    .hsync   (scan_hsync),
    .vsync   (scan_vsync),
    .visible (scan_visible)
  );

  frame_buffer fb_inst (
    .clk     (clk),
    .rd_en   (rd_en),
    .rd_addr (rd_addr),
    .rd_data (rd_data),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data)
  );

  fade_stage fade_inst (
    .clk        (clk),
    .rst        (rst),
    .rd_valid   (rd_en),
    .rd_data    (rd_data),
    .rd_addr    (rd_addr),
    .hsync_in   (scan_hsync),
    .vsync_in   (scan_vsync),
    .visible_in (scan_visible),
    .vga_valid  (vga_valid),
    .vga_hsync  (vga_hsync),
    .vga_vsync  (vga_vsync),
    .vga_red    (vga_red),
    .vga_grn    (vga_grn),
    .vga_blu    (vga_blu),
    .wb_push    (wb_push),
    .wb_addr    (wb_push_addr),
    .wb_word    (wb_push_word)
  );

  fade_writeback_fifo wb_fifo_inst (
    .clk         (clk),
    .rst         (rst),
    .push        (wb_push),
    .push_addr   (wb_push_addr),
    .push_word   (wb_push_word),
    .pop         (wb_pop),
    .pop_addr    (wb_pop_addr),
    .pop_word    (wb_pop_word),
    .empty       (wb_empty),
    .almost_full (wb_almost_full)
  );

  fb_write_arbiter arb_inst (
    .clk       (clk),
    .rst       (rst),
    .wb_empty  (wb_empty),
    .wb_addr   (wb_pop_addr),
    .wb_word   (wb_pop_word),
    .wb_pop    (wb_pop),
    .gfx_x     (gfx_x),
    .gfx_y     (gfx_y),
    .gfx_color (gfx_color),
    .gfx_valid (gfx_valid),
    .gfx_ready (gfx_ready),
    .wr_en     (wr_en),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data)
  );

endmodule

// ==== testbench/gfx_fade_asserts.sv ====
`timescale 1ns/1ns

`include "gfx_fade_settings.svh"

module gfx_fade_asserts (
  input logic clk,
  input logic rst,
  input logic gfx_ready,
  input logic vga_valid,
  input logic wb_empty,
  input logic wb_push,
  input logic wb_pop
);

  int   occupancy;
  logic rst_q;

  // shadow of the writeback FIFO fill level
  always @(posedge clk) begin
    rst_q <= rst;
    if (rst) begin
      occupancy <= 0;
    end else begin
      occupancy <= occupancy + int'(wb_push) - int'(wb_pop && !wb_empty);
    end
  end

  // drawing must wait while writebacks are queued
  a_ready_blocked: assert property (@(posedge clk) disable iff (rst)
    (occupancy != 0) |-> !gfx_ready)
    else $error("gfx_ready high with pending writebacks");

  a_quiet_in_reset: assert property (@(posedge clk) (rst && rst_q) |-> !vga_valid)
    else $error("vga_valid high during reset");

  a_no_push_full: assert property (@(posedge clk) disable iff (rst)
    (occupancy >= `WB_FIFO_DEPTH) |-> !wb_push)
    else $error("writeback pushed into a full FIFO");

endmodule

bind gfx_fade_display gfx_fade_asserts asserts_inst (
  .clk       (clk),
  .rst       (rst),
  .gfx_ready (gfx_ready),
  .vga_valid (vga_valid),
  .wb_empty  (wb_empty),
  .wb_push   (wb_push),
  .wb_pop    (wb_pop)
);

// ==== testbench/tb_gfx_fade.sv ====
`timescale 1ns/1ns

`include "gfx_fade_settings.svh"

module tb_gfx_fade
  import gfx_fade_pkg::*;
;

  logic clk, rst, gfx_valid, vga_enable;
  col_t gfx_x;
  row_t gfx_y;
  pixel_t gfx_color;
  logic gfx_ready, vga_valid, vga_hsync, vga_vsync;
  channel_t vga_red, vga_grn, vga_blu;

  // reference framebuffer and scan bookkeeping
  pixel_t model_color [`FB_WORDS];
  int model_age [`FB_WORDS];
  int sample_count, errors, checks, vs_low, px, py, addr, watch_addr;
  int hs_low [`V_TOTAL];
  bit vis, exp_hs, exp_vs, watch_on;
  pixel_t exp_c, act;
  pixel_t watch_q [$];
  string test_name;

  gfx_fade_display DUT (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic check_value(input int expected, input int actual);
    checks++;
    if (expected != actual) begin
      errors++;
      $display("FAILED %s expected %h actual %h", test_name, expected, actual);
    end
  endtask

  task automatic abort_on_timeout(input string what);
    $display("timeout while waiting for %s", what);
    $display("TEST FAIL");
    $finish;
  endtask

  // each vga_valid pulse is the next position in x-major order
  always @(negedge clk) begin
    if (!rst && vga_valid === 1'b1) begin
      px = sample_count % `H_TOTAL;
      py = (sample_count / `H_TOTAL) % `V_TOTAL;
      vis = (px < `H_VISIBLE) && (py < `V_VISIBLE);
      exp_hs = !(px >= `H_VISIBLE + `H_FRONT && px < `H_VISIBLE + `H_FRONT + `H_SYNC);
      exp_vs = !(py >= `V_VISIBLE + `V_FRONT && py < `V_VISIBLE + `V_FRONT + `V_SYNC);
      addr = py * `H_VISIBLE + px;
      exp_c = vis ? model_color[addr] : '0;
      act = {vga_red, vga_grn, vga_blu};
      check_value(int'(exp_hs), int'(vga_hsync));
      check_value(int'(exp_vs), int'(vga_vsync));
      check_value(int'(exp_c), int'(act));
      if (vis && model_color[addr] != '0 && model_age[addr] != 0) begin
        model_age[addr]--;
        if (model_age[addr] == `AGE_DIM) begin
          model_color[addr] = {model_color[addr][11:8] >> 1, model_color[addr][7:4] >> 1,
                               model_color[addr][3:0] >> 1};
        end
        if (model_age[addr] == 0) model_color[addr] = '0;
      end
      if (sample_count < `H_TOTAL * `V_TOTAL) begin
        if (!vga_hsync) hs_low[py]++;
        if (!vga_vsync) vs_low++;
      end
      if (watch_on && vis && addr == watch_addr) watch_q.push_back(act);
      sample_count++;
    end
  end

  // holds the word at the port until accepted
  task automatic draw_pixel(input int x, input int y, input pixel_t color);
    int waited;
    waited = 0;
    @(posedge clk);
    gfx_x <= col_t'(x);
    gfx_y <= row_t'(y);
    gfx_color <= color;
    gfx_valid <= 1'b1;
    do begin
      @(negedge clk);
      if (++waited > 2000) abort_on_timeout("gfx_ready");
    end while (!gfx_ready);
    @(posedge clk);
    gfx_valid <= 1'b0;
    model_color[y * `H_VISIBLE + x] = color;
    model_age[y * `H_VISIBLE + x] = `AGE_NEW;
  endtask

  // scan until the sample count reaches target, then stop and let writebacks drain
  task automatic run_until(input int target);
    int waited;
    waited = 0;
    @(posedge clk);
    vga_enable <= 1'b1;
    while (sample_count < target) begin
      @(negedge clk);
      if (++waited > 50000) abort_on_timeout("scan samples");
    end
    @(posedge clk);
    vga_enable <= 1'b0;
    repeat (4) @(negedge clk);
    waited = 0;
    while (!gfx_ready) begin
      @(negedge clk);
      if (++waited > 200) abort_on_timeout("writeback drain");
    end
  endtask

  task automatic idle_after_reset();
    test_name = "idle_after_reset";
    repeat (20) begin
      @(negedge clk);
      check_value(0, int'(vga_valid));
      check_value(1, int'(gfx_ready));
    end
  endtask

  task automatic frame_timing();
    test_name = "frame_timing";
    run_until(`H_TOTAL * `V_TOTAL);
    for (int y = 0; y < `V_TOTAL; y++) check_value(`H_SYNC, hs_low[y]);
    check_value(`V_SYNC * `H_TOTAL, vs_low);
  endtask

  task automatic random_draw();
    test_name = "random_draw";
    for (int i = 0; i < 6; i++) begin
      draw_pixel($urandom % `H_VISIBLE, $urandom % `V_VISIBLE, pixel_t'($urandom % 4095 + 1));
    end
    run_until(sample_count + `H_TOTAL * `V_TOTAL);
  endtask

  task automatic fade_sequence();
    pixel_t c, half;
    test_name = "fade_sequence";
    c = pixel_t'($urandom % 4095 + 1);
    half = {c[11:8] >> 1, c[7:4] >> 1, c[3:0] >> 1};
    watch_addr = 5 * `H_VISIBLE + 7;
    watch_q.delete();
    watch_on = 1'b1;
    draw_pixel(7, 5, c);
    run_until(sample_count + 6 * `H_TOTAL * `V_TOTAL);
    watch_on = 1'b0;
    check_value(6, watch_q.size());
    if (watch_q.size() >= 6) begin
      check_value(int'(c), int'(watch_q[0]));
      check_value(int'(c), int'(watch_q[1]));
      check_value(int'(half), int'(watch_q[2]));
      check_value(int'(half), int'(watch_q[3]));
      check_value(0, int'(watch_q[4]));
      check_value(0, int'(watch_q[5]));
    end
  endtask

  task automatic stall_and_draw();
    int waited, x, y, row;
    pixel_t c;
    test_name = "stall_and_draw";
    for (int i = 0; i < 4; i++) begin
      draw_pixel($urandom % `H_VISIBLE, $urandom % `V_VISIBLE, pixel_t'($urandom % 4095 + 1));
    end
    run_until(sample_count + 50 + $urandom % 100);
    repeat (1 + $urandom % 40) @(posedge clk);
    run_until(sample_count + `H_TOTAL * `V_TOTAL);
    // light a whole line ahead of the scan so its writebacks keep the FIFO busy
    row = ((sample_count / `H_TOTAL) % `V_TOTAL + 2) % `V_VISIBLE;
    for (int i = 0; i < `H_VISIBLE; i++) begin
      draw_pixel(i, row, pixel_t'($urandom % 4095 + 1));
    end
    @(posedge clk);
    vga_enable <= 1'b1;
    waited = 0;
    while (!((sample_count / `H_TOTAL) % `V_TOTAL == row && sample_count % `H_TOTAL >= 6)) begin
      @(negedge clk);
      if (++waited > 2000) abort_on_timeout("lit line");
    end
    // writebacks of the lit line are pending, so drawing has to wait
    check_value(0, int'(gfx_ready));
    x = $urandom % `H_VISIBLE;
    y = (row + 6) % `V_VISIBLE;
    c = pixel_t'($urandom % 4095 + 1);
    watch_addr = y * `H_VISIBLE + x;
    watch_q.delete();
    watch_on = 1'b1;
    draw_pixel(x, y, c);
    run_until(sample_count + `H_TOTAL * `V_TOTAL);
    watch_on = 1'b0;
    check_value(1, watch_q.size());
    if (watch_q.size() > 0) check_value(int'(c), int'(watch_q[0]));
  endtask

  initial begin
    void'($urandom(32'hcd74));
    rst = 1'b1;
    gfx_valid = 1'b0;
    gfx_x = '0;
    gfx_y = '0;
    gfx_color = '0;
    vga_enable = 1'b0;
    watch_on = 1'b0;
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    idle_after_reset();
    // memory has no reset, so paint every pixel black first
    for (int y = 0; y < `V_VISIBLE; y++) begin
      for (int x = 0; x < `H_VISIBLE; x++) draw_pixel(x, y, '0);
    end
    frame_timing();
    random_draw();
    fade_sequence();
    stall_and_draw();
    $display("errors: %0d of %0d checks, %0d samples", errors, checks, sample_count);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// ==== tb.f ====
+incdir+hw
hw/gfx_fade_pkg.sv
hw/vga_scan_timing.sv
hw/frame_buffer.sv
hw/fade_stage.sv
hw/fade_writeback_fifo.sv
hw/fb_write_arbiter.sv
hw/gfx_fade_display.sv
testbench/gfx_fade_asserts.sv
testbench/tb_gfx_fade.sv

// ==== run.sh ====
#!/bin/sh
# build and run the testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tb_gfx_fade -f tb.f

out=$(./obj_dir/Vtb_gfx_fade)
echo "$out"

echo "$out" | grep -qx "TEST PASS"
